//--- hdl/core_cfg_pkg.sv
package core_cfg_pkg;

    // datapath width of operands and results
    localparam int XLEN_DEF = 32;

    // program counter width, fixed for the whole core
    localparam int PC_W = 32;

    // architectural register count
    localparam int REG_NUM_DEF = 16;

    // reorder buffer entries
    // must stay a power of two so pointers wrap on their own
    localparam int ROB_DEPTH_DEF = 8;

endpackage

//--- hdl/alu_op_pkg.sv
package alu_op_pkg;

    localparam int OP_W = 3;

    // operation codes
    localparam logic [OP_W-1:0] OP_ADD = 3'd0;
    localparam logic [OP_W-1:0] OP_SUB = 3'd1;
    localparam logic [OP_W-1:0] OP_AND = 3'd2;
    localparam logic [OP_W-1:0] OP_XOR = 3'd3;
    localparam logic [OP_W-1:0] OP_MUL = 3'd4;

    // class split, everything that is not a multiply goes to the alu
    function automatic logic is_mul_op(input logic [OP_W-1:0] op);
        return (op == OP_MUL);
    endfunction

endpackage

//--- hdl/dispatch_unit.sv
`timescale 1ns/10ps
module dispatch_unit #(
    parameter int XLEN      = 32,
    parameter int REG_NUM   = 16,
    parameter int ROB_DEPTH = 8
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          in_valid_i,
    input  logic [core_cfg_pkg::PC_W-1:0] in_pc_i,
    input  logic [alu_op_pkg::OP_W-1:0]   in_op_i,
    input  logic [XLEN-1:0]               in_a_i,
    input  logic [XLEN-1:0]               in_b_i,
    input  logic [$clog2(REG_NUM)-1:0]    in_dst_i,
    input  logic                          in_dst_valid_i,
    input  logic                          credit_return_i,
    output logic                          in_ready_o,
    output logic                          dp_valid_o,
    output logic [$clog2(ROB_DEPTH)-1:0]  dp_addr_o,
    output logic [core_cfg_pkg::PC_W-1:0] dp_pc_o,
    output logic [$clog2(REG_NUM)-1:0]    dp_dst_o,
    output logic                          dp_dst_valid_o,
    output logic                          alu_issue_valid_o,
    output logic                          mul_issue_valid_o,
    output logic [$clog2(ROB_DEPTH)-1:0]  issue_tag_o,
    output logic [alu_op_pkg::OP_W-1:0]   issue_op_o,
    output logic [XLEN-1:0]               issue_a_o,
    output logic [XLEN-1:0]               issue_b_o
);

    localparam int TAG_W = $clog2(ROB_DEPTH);
    localparam int CRD_W = $clog2(ROB_DEPTH + 1);

    logic [TAG_W-1:0] tail;
    logic [CRD_W-1:0] credits;
    logic             accept;

    // one credit per free rob entry
    assign in_ready_o = (credits != '0);
    assign accept     = in_valid_i & in_ready_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            tail    <= '0;
            credits <= CRD_W'(ROB_DEPTH);
        end else begin
            // power of two depth, so the tail wraps by overflow
            if (accept) begin
                tail <= tail + 1'b1;
            end
            if (accept && !credit_return_i) begin
                credits <= credits - 1'b1;
            end else if (!accept && credit_return_i) begin
                credits <= credits + 1'b1;
            end
        end
    end

    // rob allocation, written at the accepting edge
    assign dp_valid_o     = accept;
    assign dp_addr_o      = tail;
    assign dp_pc_o        = in_pc_i;
    assign dp_dst_o       = in_dst_i;
    assign dp_dst_valid_o = in_dst_valid_i;

    // steer by op class, tag is the rob entry
    assign mul_issue_valid_o = accept & alu_op_pkg::is_mul_op(in_op_i);
    assign alu_issue_valid_o = accept & ~alu_op_pkg::is_mul_op(in_op_i);
    assign issue_tag_o       = tail;
    assign issue_op_o        = in_op_i;
    assign issue_a_o         = in_a_i;
    assign issue_b_o         = in_b_i;

endmodule

//--- hdl/int_alu.sv
`timescale 1ns/10ps
module int_alu #(
    parameter int XLEN      = 32,
    parameter int ROB_DEPTH = 8
) (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         issue_valid_i,
    input  logic [$clog2(ROB_DEPTH)-1:0] issue_tag_i,
    input  logic [alu_op_pkg::OP_W-1:0]  issue_op_i,
    input  logic [XLEN-1:0]              issue_a_i,
    input  logic [XLEN-1:0]              issue_b_i,
    output logic                         done_valid_o,
    output logic [$clog2(ROB_DEPTH)-1:0] done_tag_o,
    output logic [XLEN-1:0]              done_data_o
);

    logic [XLEN-1:0] result;

    // wraps at xlen bits
    always_comb begin
        case (issue_op_i)
            alu_op_pkg::OP_ADD: result = issue_a_i + issue_b_i;
            alu_op_pkg::OP_SUB: result = issue_a_i - issue_b_i;
            alu_op_pkg::OP_AND: result = issue_a_i & issue_b_i;
            alu_op_pkg::OP_XOR: result = issue_a_i ^ issue_b_i;
            default:            result = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            done_valid_o <= 1'b0;
        end else begin
            done_valid_o <= issue_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        done_tag_o  <= issue_tag_i;
        done_data_o <= result;
    end

endmodule

//--- hdl/mul_unit.sv
`timescale 1ns/10ps
module mul_unit #(
    parameter int XLEN      = 32,
    parameter int ROB_DEPTH = 8
) (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         issue_valid_i,
    input  logic [$clog2(ROB_DEPTH)-1:0] issue_tag_i,
    input  logic [XLEN-1:0]              issue_a_i,
    input  logic [XLEN-1:0]              issue_b_i,
    output logic                         done_valid_o,
    output logic [$clog2(ROB_DEPTH)-1:0] done_tag_o,
    output logic [XLEN-1:0]              done_data_o
);

    localparam int TAG_W = $clog2(ROB_DEPTH);

    // stage 1 holds operands, stage 2 the product
    logic             s1_valid;
    logic [TAG_W-1:0] s1_tag;
    logic [XLEN-1:0]  s1_a;
    logic [XLEN-1:0]  s1_b;
    logic             s2_valid;
    logic [TAG_W-1:0] s2_tag;
    logic [XLEN-1:0]  s2_prod;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            s1_valid     <= 1'b0;
            s2_valid     <= 1'b0;
            done_valid_o <= 1'b0;
        end else begin
            s1_valid     <= issue_valid_i;
            s2_valid     <= s1_valid;
            done_valid_o <= s2_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        s1_tag      <= issue_tag_i;
        s1_a        <= issue_a_i;
        s1_b        <= issue_b_i;
        s2_tag      <= s1_tag;
        // low half of the product only
        s2_prod     <= s1_a * s1_b;
        done_tag_o  <= s2_tag;
        done_data_o <= s2_prod;
    end

endmodule

//--- hdl/reorder_buffer.sv
`timescale 1ns/10ps
module reorder_buffer #(
    parameter int XLEN      = 32,
    parameter int REG_NUM   = 16,
    parameter int ROB_DEPTH = 8
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          dp_valid_i,
    input  logic [$clog2(ROB_DEPTH)-1:0]  dp_addr_i,
    input  logic [core_cfg_pkg::PC_W-1:0] dp_pc_i,
    input  logic [$clog2(REG_NUM)-1:0]    dp_dst_i,
    input  logic                          dp_dst_valid_i,
    input  logic                          alu_done_valid_i,
    input  logic [$clog2(ROB_DEPTH)-1:0]  alu_done_tag_i,
    input  logic [XLEN-1:0]               alu_done_data_i,
    input  logic                          mul_done_valid_i,
    input  logic [$clog2(ROB_DEPTH)-1:0]  mul_done_tag_i,
    input  logic [XLEN-1:0]               mul_done_data_i,
    output logic                          commit_valid_o,
    output logic [core_cfg_pkg::PC_W-1:0] commit_pc_o,
    output logic                          commit_we_o,
    output logic [$clog2(REG_NUM)-1:0]    commit_dst_o,
    output logic [XLEN-1:0]               commit_data_o,
    output logic                          credit_return_o
);

    localparam int TAG_W = $clog2(ROB_DEPTH);
    localparam int REG_W = $clog2(REG_NUM);

    // entry state
    logic [ROB_DEPTH-1:0]          valid;
    logic [ROB_DEPTH-1:0]          finish;
    logic [ROB_DEPTH-1:0]          dst_valid;
    logic [core_cfg_pkg::PC_W-1:0] pc_q   [ROB_DEPTH];
    logic [REG_W-1:0]              dst_q  [ROB_DEPTH];
    logic [XLEN-1:0]               data_q [ROB_DEPTH];

    logic [TAG_W-1:0] head;
    logic             commit;

    // head retires once it has been dispatched and has finished
    assign commit = valid[head] & finish[head];

    assign commit_valid_o  = commit;
    assign commit_we_o     = commit & dst_valid[head];
    assign commit_pc_o     = pc_q[head];
    assign commit_dst_o    = dst_q[head];
    assign commit_data_o   = data_q[head];
    assign credit_return_o = commit;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            head   <= '0;
            valid  <= '0;
            finish <= '0;
        end else begin
            if (commit) begin
                valid[head]  <= 1'b0;
                finish[head] <= 1'b0;
                head         <= head + 1'b1;
            end
            // credits keep dispatch off the committing entry
            if (dp_valid_i) begin
                valid[dp_addr_i]  <= 1'b1;
                finish[dp_addr_i] <= 1'b0;
            end
            // each unit has its own port, tags never collide
            if (alu_done_valid_i) begin
                finish[alu_done_tag_i] <= 1'b1;
            end
            if (mul_done_valid_i) begin
                finish[mul_done_tag_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (dp_valid_i) begin
            pc_q[dp_addr_i]      <= dp_pc_i;
            dst_q[dp_addr_i]     <= dp_dst_i;
            dst_valid[dp_addr_i] <= dp_dst_valid_i;
        end
        if (alu_done_valid_i) begin
            data_q[alu_done_tag_i] <= alu_done_data_i;
        end
        if (mul_done_valid_i) begin
            data_q[mul_done_tag_i] <= mul_done_data_i;
        end
    end

endmodule

//--- hdl/arch_regfile.sv
`timescale 1ns/10ps
module arch_regfile #(
    parameter int XLEN    = 32,
    parameter int REG_NUM = 16
) (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       we_i,
    input  logic [$clog2(REG_NUM)-1:0] waddr_i,
    input  logic [XLEN-1:0]            wdata_i,
    input  logic [$clog2(REG_NUM)-1:0] raddr_i,
    output logic [XLEN-1:0]            rdata_o
);

    logic [XLEN-1:0] regs [REG_NUM];

    // written only by commit
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // async read
    assign rdata_o = regs[raddr_i];

endmodule

//--- hdl/ooo_backend_top.sv
`timescale 1ns/10ps
module ooo_backend_top #(
    parameter int XLEN      = core_cfg_pkg::XLEN_DEF,
    parameter int REG_NUM   = core_cfg_pkg::REG_NUM_DEF,
    parameter int ROB_DEPTH = core_cfg_pkg::ROB_DEPTH_DEF
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          in_valid_i,
    input  logic [core_cfg_pkg::PC_W-1:0] in_pc_i,
    input  logic [alu_op_pkg::OP_W-1:0]   in_op_i,
    input  logic [XLEN-1:0]               in_a_i,
    input  logic [XLEN-1:0]               in_b_i,
    input  logic [$clog2(REG_NUM)-1:0]    in_dst_i,
    input  logic                          in_dst_valid_i,
    output logic                          in_ready_o,
    output logic                          commit_valid_o,
    output logic [core_cfg_pkg::PC_W-1:0] commit_pc_o,
    output logic                          commit_we_o,
    output logic [$clog2(REG_NUM)-1:0]    commit_dst_o,
    output logic [XLEN-1:0]               commit_data_o,
    input  logic [$clog2(REG_NUM)-1:0]    rd_addr_i,
    output logic [XLEN-1:0]               rd_data_o
);

    localparam int TAG_W = $clog2(ROB_DEPTH);
    localparam int REG_W = $clog2(REG_NUM);

    logic                          credit_return;
    logic                          dp_valid;
    logic [TAG_W-1:0]              dp_addr;
    logic [core_cfg_pkg::PC_W-1:0] dp_pc;
    logic [REG_W-1:0]              dp_dst;
    logic                          dp_dst_valid;
    logic                          alu_issue_valid;
    logic                          mul_issue_valid;
    logic [TAG_W-1:0]              issue_tag;
    logic [alu_op_pkg::OP_W-1:0]   issue_op;
    logic [XLEN-1:0]               issue_a;
    logic [XLEN-1:0]               issue_b;
    logic                          alu_done_valid;
    logic [TAG_W-1:0]              alu_done_tag;
    logic [XLEN-1:0]               alu_done_data;
    logic                          mul_done_valid;
    logic [TAG_W-1:0]              mul_done_tag;
    logic [XLEN-1:0]               mul_done_data;

    dispatch_unit #(
        .XLEN      (XLEN),
        .REG_NUM   (REG_NUM),
        .ROB_DEPTH (ROB_DEPTH)
    ) u_dispatch (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .in_valid_i        (in_valid_i),
        .in_pc_i           (in_pc_i),
        .in_op_i           (in_op_i),
        .in_a_i            (in_a_i),
        .in_b_i            (in_b_i),
        .in_dst_i          (in_dst_i),
        .in_dst_valid_i    (in_dst_valid_i),
        .credit_return_i   (credit_return),
        .in_ready_o        (in_ready_o),
        .dp_valid_o        (dp_valid),
        .dp_addr_o         (dp_addr),
        .dp_pc_o           (dp_pc),
        .dp_dst_o          (dp_dst),
        .dp_dst_valid_o    (dp_dst_valid),
        .alu_issue_valid_o (alu_issue_valid),
        .mul_issue_valid_o (mul_issue_valid),
        .issue_tag_o       (issue_tag),
        .issue_op_o        (issue_op),
        .issue_a_o         (issue_a),
        .issue_b_o         (issue_b)
    );

    int_alu #(
        .XLEN      (XLEN),
        .ROB_DEPTH (ROB_DEPTH)
    ) u_alu (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .issue_valid_i (alu_issue_valid),
        .issue_tag_i   (issue_tag),
        .issue_op_i    (issue_op),
        .issue_a_i     (issue_a),
        .issue_b_i     (issue_b),
        .done_valid_o  (alu_done_valid),
        .done_tag_o    (alu_done_tag),
        .done_data_o   (alu_done_data)
    );

    mul_unit #(
        .XLEN      (XLEN),
        .ROB_DEPTH (ROB_DEPTH)
    ) u_mul (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .issue_valid_i (mul_issue_valid),
        .issue_tag_i   (issue_tag),
        .issue_a_i     (issue_a),
        .issue_b_i     (issue_b),
        .done_valid_o  (mul_done_valid),
        .done_tag_o    (mul_done_tag),
        .done_data_o   (mul_done_data)
    );

    reorder_buffer #(
        .XLEN      (XLEN),
        .REG_NUM   (REG_NUM),
        .ROB_DEPTH (ROB_DEPTH)
    ) u_rob (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .dp_valid_i       (dp_valid),
        .dp_addr_i        (dp_addr),
        .dp_pc_i          (dp_pc),
        .dp_dst_i         (dp_dst),
        .dp_dst_valid_i   (dp_dst_valid),
        .alu_done_valid_i (alu_done_valid),
        .alu_done_tag_i   (alu_done_tag),
        .alu_done_data_i  (alu_done_data),
        .mul_done_valid_i (mul_done_valid),
        .mul_done_tag_i   (mul_done_tag),
        .mul_done_data_i  (mul_done_data),
        .commit_valid_o   (commit_valid_o),
        .commit_pc_o      (commit_pc_o),
        .commit_we_o      (commit_we_o),
        .commit_dst_o     (commit_dst_o),
        .commit_data_o    (commit_data_o),
        .credit_return_o  (credit_return)
    );

    arch_regfile #(
        .XLEN    (XLEN),
        .REG_NUM (REG_NUM)
    ) u_arf (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .we_i    (commit_we_o),
        .waddr_i (commit_dst_o),
        .wdata_i (commit_data_o),
        .raddr_i (rd_addr_i),
        .rdata_o (rd_data_o)
    );

endmodule

//--- dv/ooo_backend_asserts.sv
`timescale 1ns/10ps
module ooo_backend_asserts #(
    parameter int ROB_DEPTH = 8
) (
    input logic clk_i,
    input logic reset_i,
    input logic in_valid_i,
    input logic in_ready_i,
    input logic commit_valid_i,
    input logic credit_return_i
);

    int outstanding;
    int fail_count = 0;

    // accepted but not yet committed
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(in_valid_i & in_ready_i) - int'(commit_valid_i);
        end
    end

    // a returned credit always reopens the input
    credit_reopens_input: assert property (
        @(posedge clk_i) disable iff (reset_i) credit_return_i |=> in_ready_i
    ) else begin
        fail_count++;
        $error("credit returned but input stayed blocked");
    end

    commit_needs_outstanding: assert property (
        @(posedge clk_i) disable iff (reset_i) commit_valid_i |-> (outstanding != 0)
    ) else begin
        fail_count++;
        $error("commit with no accepted instruction outstanding");
    end

    // rob full means no credits left
    ready_low_when_full: assert property (
        @(posedge clk_i) disable iff (reset_i) (outstanding == ROB_DEPTH) |-> !in_ready_i
    ) else begin
        fail_count++;
        $error("input ready while the reorder buffer is full");
    end

endmodule

bind ooo_backend_top ooo_backend_asserts #(
    .ROB_DEPTH (ROB_DEPTH)
) u_asserts (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .in_valid_i      (in_valid_i),
    .in_ready_i      (in_ready_o),
    .commit_valid_i  (commit_valid_o),
    .credit_return_i (credit_return)
);

//--- dv/ooo_backend_tb.sv
`timescale 1ns/10ps
module ooo_backend_tb;

    localparam int XLEN       = 32;
    localparam int REG_NUM    = 16;
    localparam int ROB_DEPTH  = 4;
    localparam int REG_W      = $clog2(REG_NUM);
    localparam int OP_W       = alu_op_pkg::OP_W;
    localparam int NUM_INSTR  = 300;
    localparam int WAIT_LIMIT = 200;

    // one accepted instruction and what its commit must show
    typedef struct packed {
        logic [31:0]      pc;
        logic             is_mul;
        logic [REG_W-1:0] dst;
        logic             dst_valid;
        logic [XLEN-1:0]  result;
        logic [31:0]      accept_cycle;
    } expect_t;

    logic                          clk_i;
    logic                          reset_i;
    logic                          in_valid_i;
    logic [core_cfg_pkg::PC_W-1:0] in_pc_i;
    logic [OP_W-1:0]               in_op_i;
    logic [XLEN-1:0]               in_a_i;
    logic [XLEN-1:0]               in_b_i;
    logic [REG_W-1:0]              in_dst_i;
    logic                          in_dst_valid_i;
    logic                          in_ready_o;
    logic                          commit_valid_o;
    logic [core_cfg_pkg::PC_W-1:0] commit_pc_o;
    logic                          commit_we_o;
    logic [REG_W-1:0]              commit_dst_o;
    logic [XLEN-1:0]               commit_data_o;
    logic [REG_W-1:0]              rd_addr_i;
    logic [XLEN-1:0]               rd_data_o;

    expect_t         exp_q[$];
    logic [XLEN-1:0] reg_model [REG_NUM];
    int              cycle;
    int              error_count;
    int              commit_count;
    int              seed;
    logic [31:0]     next_pc;

    ooo_backend_top #(
        .ROB_DEPTH (ROB_DEPTH)
    ) uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    function automatic logic [XLEN-1:0] expected_result(input logic [OP_W-1:0] op,
                                                        input logic [XLEN-1:0] a,
                                                        input logic [XLEN-1:0] b);
        // all results wrap at xlen bits, mul keeps the low half
        case (op)
            alu_op_pkg::OP_ADD: return a + b;
            alu_op_pkg::OP_SUB: return a - b;
            alu_op_pkg::OP_AND: return a & b;
            alu_op_pkg::OP_XOR: return a ^ b;
            alu_op_pkg::OP_MUL: return a * b;
            default:            return '0;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[ERROR] t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
        error_count++;
    endtask

    task automatic finish_run();
        int total;
        total = error_count + uut.u_asserts.fail_count;
        $display("commits %0d, check errors %0d, assertion errors %0d",
                 commit_count, error_count, uut.u_asserts.fail_count);
        if (total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic abort_run(input string why);
        $display("%s at t=%0t", why, $time);
        error_count++;
        finish_run();
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send_instr(input logic [OP_W-1:0] op, input logic [XLEN-1:0] a,
                              input logic [XLEN-1:0] b, input logic [REG_W-1:0] dst,
                              input logic dst_valid);
        int waited;
        in_valid_i     = 1'b1;
        in_pc_i        = next_pc;
        in_op_i        = op;
        in_a_i         = a;
        in_b_i         = b;
        in_dst_i       = dst;
        in_dst_valid_i = dst_valid;
        waited         = 0;
        // held with its data until a credit comes back
        while (in_ready_o !== 1'b1 && waited < WAIT_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        if (in_ready_o !== 1'b1) begin
            abort_run("input was never ready");
        end
        next_pc = next_pc + 4;
        @(negedge clk_i);
    endtask

    task automatic check_commit();
        expect_t e;
        int      min_lat;
        if (exp_q.size() == 0) begin
            $display("commit at t=%0t with nothing outstanding", $time);
            error_count++;
            return;
        end
        e       = exp_q.pop_front();
        min_lat = e.is_mul ? 4 : 2;
        commit_count++;
        if (commit_pc_o !== e.pc) begin
            report_mismatch("commit_pc_o", commit_pc_o, e.pc);
        end
        if (commit_we_o !== e.dst_valid) begin
            report_mismatch("commit_we_o", commit_we_o, e.dst_valid);
        end
        if (commit_dst_o !== e.dst) begin
            report_mismatch("commit_dst_o", commit_dst_o, e.dst);
        end
        if (commit_data_o !== e.result) begin
            report_mismatch("commit_data_o", commit_data_o, e.result);
        end
        if (cycle - int'(e.accept_cycle) < min_lat) begin
            $display("pc 0x%08h committed %0d cycles after acceptance, minimum is %0d",
                     e.pc, cycle - int'(e.accept_cycle), min_lat);
            error_count++;
        end
        if (e.dst_valid) begin
            reg_model[e.dst] = e.result;
        end
    endtask

    // compare process, all dut state is still pre-edge here
    always @(posedge clk_i) begin
        if (reset_i) begin
            cycle <= 0;
        end else begin
            cycle <= cycle + 1;
            if (in_ready_o !== (exp_q.size() < ROB_DEPTH)) begin
                report_mismatch("in_ready_o", in_ready_o, exp_q.size() < ROB_DEPTH);
            end
            if (commit_valid_o === 1'b1) begin
                check_commit();
            end
            if (in_valid_i === 1'b1 && in_ready_o === 1'b1) begin
                exp_q.push_back('{pc: in_pc_i,
                                  is_mul: (in_op_i == alu_op_pkg::OP_MUL),
                                  dst: in_dst_i,
                                  dst_valid: in_dst_valid_i,
                                  result: expected_result(in_op_i, in_a_i, in_b_i),
                                  accept_cycle: cycle});
            end
        end
    end

    initial begin
        logic [OP_W-1:0] op;
        int              burst_left;
        int              gap;
        int              waited;
        seed           = $urandom(74);
        reset_i        = 1'b1;
        in_valid_i     = 1'b0;
        in_pc_i        = '0;
        in_op_i        = '0;
        in_a_i         = '0;
        in_b_i         = '0;
        in_dst_i       = '0;
        in_dst_valid_i = 1'b0;
        rd_addr_i      = '0;
        error_count    = 0;
        commit_count   = 0;
        burst_left     = 0;
        next_pc        = 32'h0000_1000;
        for (int r = 0; r < REG_NUM; r++) begin
            reg_model[r] = '0;
        end
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;

        if (commit_valid_o !== 1'b0) begin
            report_mismatch("commit_valid_o", commit_valid_o, 0);
        end
        if (commit_we_o !== 1'b0) begin
            report_mismatch("commit_we_o", commit_we_o, 0);
        end
        if (in_ready_o !== 1'b1) begin
            report_mismatch("in_ready_o", in_ready_o, 1);
        end

        // younger add finishes ahead of the older mul
        send_instr(alu_op_pkg::OP_MUL, 32'd7, 32'd9, REG_W'(1), 1'b1);
        send_instr(alu_op_pkg::OP_ADD, 32'd5, 32'd6, REG_W'(2), 1'b1);

        for (int i = 0; i < NUM_INSTR; i++) begin
            if (burst_left == 0 && $urandom_range(0, 7) == 0) begin
                burst_left = $urandom_range(3, 7);
            end
            // bursts are mostly mul with an odd add mixed in
            if (burst_left > 0) begin
                burst_left--;
                op = ($urandom_range(0, 3) == 0) ? alu_op_pkg::OP_ADD : alu_op_pkg::OP_MUL;
            end else begin
                op = OP_W'($urandom_range(0, 4));
            end
            send_instr(op, $urandom(), $urandom(), REG_W'($urandom_range(0, REG_NUM - 1)),
                       $urandom_range(0, 3) != 0);
            gap = (burst_left > 0 || $urandom_range(0, 1) == 0) ? 0 : $urandom_range(1, 3);
            if (gap > 0) begin
                in_valid_i = 1'b0;
                repeat (gap) @(negedge clk_i);
            end
        end
        in_valid_i = 1'b0;

        waited = 0;
        while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        if (exp_q.size() != 0) begin
            abort_run("outstanding instructions never committed");
        end

        for (int r = 0; r < REG_NUM; r++) begin
            @(negedge clk_i);
            rd_addr_i = REG_W'(r);
            @(posedge clk_i);
            if (rd_data_o !== reg_model[r]) begin
                report_mismatch($sformatf("rd_data_o[%0d]", r), rd_data_o, reg_model[r]);
            end
        end

        finish_run();
    end

endmodule

//--- compile.f
hdl/core_cfg_pkg.sv
hdl/alu_op_pkg.sv
hdl/dispatch_unit.sv
hdl/int_alu.sv
hdl/mul_unit.sv
hdl/reorder_buffer.sv
hdl/arch_regfile.sv
hdl/ooo_backend_top.sv
dv/ooo_backend_asserts.sv
dv/ooo_backend_tb.sv

//--- Bender.yml
package:
  name: ooo_backend

sources:
  - files:
      - hdl/core_cfg_pkg.sv
      - hdl/alu_op_pkg.sv
      - hdl/dispatch_unit.sv
      - hdl/int_alu.sv
      - hdl/mul_unit.sv
      - hdl/reorder_buffer.sv
      - hdl/arch_regfile.sv
      - hdl/ooo_backend_top.sv
  - target: test
    files:
      - dv/ooo_backend_asserts.sv
      - dv/ooo_backend_tb.sv
